/* hdl/mdu_consts.svh */
`ifndef MDU_CONSTS_SVH
`define MDU_CONSTS_SVH

// register and word widths
`define MDU_XLEN 64
`define MDU_WLEN 32

// iteration counter width and step counts
`define MDU_CNT_W 6
`define MDU_DWORD_STEPS 64
`define MDU_WORD_STEPS 32

// funct3 codes of the M extension
`define MDU_FUNCT_MUL    3'd0
`define MDU_FUNCT_MULH   3'd1
`define MDU_FUNCT_MULHSU 3'd2
`define MDU_FUNCT_MULHU  3'd3
`define MDU_FUNCT_DIV    3'd4
`define MDU_FUNCT_DIVU   3'd5
`define MDU_FUNCT_REM    3'd6
`define MDU_FUNCT_REMU   3'd7

`endif

/* hdl/mduPkg.sv */
`include "mdu_consts.svh"

package mduPkg;

    typedef logic [`MDU_XLEN-1:0]   xlenT;    // operands and results
    typedef logic [2*`MDU_XLEN-1:0] dxlenT;   // remainder/quotient reg, full product
    typedef logic [2:0]             funct3T;

    // [1] operand A signed, [0] operand B signed
    typedef logic [1:0]             signModeT;

    typedef logic [`MDU_CNT_W-1:0]  countT;

    typedef enum logic [1:0] {
        divIdle,
        divBusy,
        divValid
    } divStateT;

    typedef enum logic [1:0] {
        mulIdle,
        mulBusy,
        mulValid
    } mulStateT;

endpackage

/* hdl/mduDecode.sv */
`timescale 1ns/1ps
`include "mdu_consts.svh"

module mduDecode (
    input  logic             clock,
    input  logic             reset,
    input  logic             start,
    input  logic             flush,
    input  mduPkg::funct3T   funct3,
    input  logic             isWord,
    input  mduPkg::xlenT     operandA,
    input  mduPkg::xlenT     operandB,
    input  logic             outValid,
    output logic             ready,
    output logic             divStart,
    output logic             mulStart,
    output mduPkg::xlenT     opA,
    output mduPkg::xlenT     opB,
    output logic             wordOp,
    output mduPkg::signModeT signMode,
    output logic             selHigh,
    output logic             selRem,
    output logic             divByZero,
    output logic             divOverflow
);
    logic             busy;
    logic             accept;
    logic             isDiv;
    logic             bZero;
    logic             aMostNeg;
    logic             bMinusOne;
    mduPkg::signModeT signModeIn;

    assign ready  = !busy;
    assign accept = start && ready && !flush;
    assign isDiv  = funct3[2];

    always_comb begin
        case (funct3)
            `MDU_FUNCT_MULHSU: signModeIn = 2'b10;
            `MDU_FUNCT_MULHU, `MDU_FUNCT_DIVU, `MDU_FUNCT_REMU: signModeIn = 2'b00;
            default: signModeIn = 2'b11;
        endcase
    end

    // special cases judged at the operation's width
    assign bZero = isWord ? (operandB[`MDU_WLEN-1:0] == '0) : (operandB == '0);
    assign aMostNeg = isWord ?
        (operandA[`MDU_WLEN-1:0] == {1'b1, {(`MDU_WLEN-1){1'b0}}}) :
        (operandA == {1'b1, {(`MDU_XLEN-1){1'b0}}});
    assign bMinusOne = isWord ? (&operandB[`MDU_WLEN-1:0]) : (&operandB);

    always_ff @(posedge clock) begin
        if (reset) begin
            busy     <= 1'b0;
            divStart <= 1'b0;
            mulStart <= 1'b0;
        end else begin
            divStart <= accept && isDiv;
            mulStart <= accept && !isDiv;
            if (flush || outValid) begin
                busy <= 1'b0;
            end else if (accept) begin
                busy <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            opA         <= operandA;
            opB         <= operandB;
            wordOp      <= isWord;
            signMode    <= signModeIn;
            selHigh     <= !isDiv && !isWord && (funct3 != `MDU_FUNCT_MUL); // mulw takes low
            selRem      <= (funct3 == `MDU_FUNCT_REM) || (funct3 == `MDU_FUNCT_REMU);
            divByZero   <= isDiv && bZero;
            divOverflow <= isDiv && (signModeIn == 2'b11) && aMostNeg && bMinusOne;
        end
    end

    // a result only closes an operation in flight, never one just started
    assert property (@(posedge clock) disable iff (reset)
        outValid |-> busy && !divStart && !mulStart)
        else $error("outValid without an operation in flight or with a new start");

endmodule

/* hdl/iterDivider.sv */
`timescale 1ns/1ps
`include "mdu_consts.svh"

module iterDivider (
    input  logic             clock,
    input  logic             reset,
    input  logic             divStart,
    input  logic             flush,
    input  mduPkg::xlenT     opA,
    input  mduPkg::xlenT     opB,
    input  logic             wordOp,
    input  mduPkg::signModeT signMode,
    output logic             divDone,
    output mduPkg::xlenT     quotient,
    output mduPkg::xlenT     remainder
);
    mduPkg::divStateT   state;
    mduPkg::divStateT   nextState;
    mduPkg::countT      count;
    mduPkg::dxlenT      remQuo;     // partial remainder above the quotient bits
    logic               remTop;     // bit shifted out of remQuo in double ops
    logic               signedDiv;
    logic               dvdNeg;
    logic               dvsNeg;
    mduPkg::xlenT       dvdAbs;
    mduPkg::xlenT       dvsAbs;
    mduPkg::xlenT       dvdMag;
    mduPkg::xlenT       dvsMag;
    mduPkg::dxlenT      dvsAligned;
    logic [`MDU_XLEN:0] cmpRem;
    logic [`MDU_XLEN:0] cmpDvs;
    logic               remGe;
    mduPkg::dxlenT      subRes;
    mduPkg::xlenT       quoRaw;
    mduPkg::xlenT       remRaw;

    assign signedDiv = signMode == 2'b11;
    assign dvdNeg = signedDiv && (wordOp ? opA[`MDU_WLEN-1] : opA[`MDU_XLEN-1]);
    assign dvsNeg = signedDiv && (wordOp ? opB[`MDU_WLEN-1] : opB[`MDU_XLEN-1]);

    // magnitudes with the upper half dropped for word ops
    assign dvdAbs = dvdNeg ? ~opA + 1'b1 : opA;
    assign dvsAbs = dvsNeg ? ~opB + 1'b1 : opB;
    assign dvdMag = wordOp ? {{(`MDU_XLEN-`MDU_WLEN){1'b0}}, dvdAbs[`MDU_WLEN-1:0]} : dvdAbs;
    assign dvsMag = wordOp ? {{(`MDU_XLEN-`MDU_WLEN){1'b0}}, dvsAbs[`MDU_WLEN-1:0]} : dvsAbs;

    assign dvsAligned = wordOp ? mduPkg::dxlenT'(dvsMag) << `MDU_WLEN :
                                 mduPkg::dxlenT'(dvsMag) << `MDU_XLEN;

    // one extra bit so a shifted remainder never overflows the compare
    assign cmpRem = wordOp ?
        {{(`MDU_XLEN-`MDU_WLEN){1'b0}}, remQuo[`MDU_XLEN:`MDU_WLEN]} :
        {remTop, remQuo[2*`MDU_XLEN-1:`MDU_XLEN]};
    assign cmpDvs = {1'b0, dvsMag};
    assign remGe  = cmpRem >= cmpDvs;
    assign subRes = remQuo - dvsAligned + 1'b1;   // subtract and set quotient bit

    always_comb begin
        nextState = state;
        case (state)
            mduPkg::divIdle: begin
                if (divStart && !flush) begin
                    nextState = mduPkg::divBusy;
                end
            end
            mduPkg::divBusy: begin
                if (flush) begin
                    nextState = mduPkg::divIdle;
                end else if (count == '0) begin
                    nextState = mduPkg::divValid;
                end
            end
            mduPkg::divValid: nextState = mduPkg::divIdle;
            default: nextState = mduPkg::divIdle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= mduPkg::divIdle;
            count <= '0;
        end else begin
            state <= nextState;
            if (state == mduPkg::divIdle) begin
                count <= wordOp ? mduPkg::countT'(`MDU_WORD_STEPS - 1) :
                                  mduPkg::countT'(`MDU_DWORD_STEPS - 1);
            end else if (state == mduPkg::divBusy && count != '0) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (state == mduPkg::divIdle && divStart) begin
            remQuo <= mduPkg::dxlenT'(dvdMag) << 1;
            remTop <= 1'b0;
        end else if (state == mduPkg::divBusy) begin
            if (count == '0) begin
                remQuo <= remGe ? subRes : remQuo;  // no shift on the last step
            end else begin
                {remTop, remQuo} <= {(remGe ? subRes : remQuo), 1'b0};
            end
        end
    end

    assign quoRaw = wordOp ?
        {{(`MDU_XLEN-`MDU_WLEN){1'b0}}, remQuo[`MDU_WLEN-1:0]} :
        remQuo[`MDU_XLEN-1:0];
    assign remRaw = wordOp ?
        {{(`MDU_XLEN-`MDU_WLEN){1'b0}}, remQuo[`MDU_XLEN-1:`MDU_WLEN]} :
        remQuo[2*`MDU_XLEN-1:`MDU_XLEN];

    // remainder follows the dividend's sign
    assign quotient  = (dvdNeg ^ dvsNeg) ? ~quoRaw + 1'b1 : quoRaw;
    assign remainder = dvdNeg ? ~remRaw + 1'b1 : remRaw;
    assign divDone   = state == mduPkg::divValid;

    // a new divide only ever meets an idle divider
    assert property (@(posedge clock) disable iff (reset)
        divStart |-> state == mduPkg::divIdle)
        else $error("divide start while the divider was still running");

endmodule

/* hdl/seqMultiplier.sv */
`timescale 1ns/1ps
`include "mdu_consts.svh"

module seqMultiplier (
    input  logic             clock,
    input  logic             reset,
    input  logic             mulStart,
    input  logic             flush,
    input  mduPkg::xlenT     opA,
    input  mduPkg::xlenT     opB,
    input  logic             wordOp,
    input  mduPkg::signModeT signMode,
    output logic             mulDone,
    output mduPkg::xlenT     productLow,
    output mduPkg::xlenT     productHigh
);
    mduPkg::mulStateT state;
    mduPkg::mulStateT nextState;
    mduPkg::countT    count;
    mduPkg::dxlenT    acc;
    mduPkg::dxlenT    mcand;      // shifted left each step
    mduPkg::xlenT     mplier;     // shifted right each step
    logic             aNeg;
    logic             bNeg;
    mduPkg::xlenT     aAbs;
    mduPkg::xlenT     bAbs;
    mduPkg::xlenT     aMag;
    mduPkg::xlenT     bMag;
    mduPkg::dxlenT    product;

    // mulhsu has only A signed
    assign aNeg = signMode[1] && (wordOp ? opA[`MDU_WLEN-1] : opA[`MDU_XLEN-1]);
    assign bNeg = signMode[0] && (wordOp ? opB[`MDU_WLEN-1] : opB[`MDU_XLEN-1]);

    assign aAbs = aNeg ? ~opA + 1'b1 : opA;
    assign bAbs = bNeg ? ~opB + 1'b1 : opB;
    assign aMag = wordOp ? {{(`MDU_XLEN-`MDU_WLEN){1'b0}}, aAbs[`MDU_WLEN-1:0]} : aAbs;
    assign bMag = wordOp ? {{(`MDU_XLEN-`MDU_WLEN){1'b0}}, bAbs[`MDU_WLEN-1:0]} : bAbs;

    always_comb begin
        nextState = state;
        case (state)
            mduPkg::mulIdle: begin
                if (mulStart && !flush) begin
                    nextState = mduPkg::mulBusy;
                end
            end
            mduPkg::mulBusy: begin
                if (flush) begin
                    nextState = mduPkg::mulIdle;
                end else if (count == '0) begin
                    nextState = mduPkg::mulValid;
                end
            end
            mduPkg::mulValid: nextState = mduPkg::mulIdle;
            default: nextState = mduPkg::mulIdle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= mduPkg::mulIdle;
            count <= '0;
        end else begin
            state <= nextState;
            if (state == mduPkg::mulIdle) begin
                count <= wordOp ? mduPkg::countT'(`MDU_WORD_STEPS - 1) :
                                  mduPkg::countT'(`MDU_DWORD_STEPS - 1);
            end else if (state == mduPkg::mulBusy && count != '0) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (state == mduPkg::mulIdle && mulStart) begin
            acc    <= '0;
            mcand  <= mduPkg::dxlenT'(aMag);
            mplier <= bMag;
        end else if (state == mduPkg::mulBusy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign product     = (aNeg ^ bNeg) ? ~acc + 1'b1 : acc;
    assign productLow  = product[`MDU_XLEN-1:0];
    assign productHigh = product[2*`MDU_XLEN-1:`MDU_XLEN];
    assign mulDone     = state == mduPkg::mulValid;

    // a start pulse only ever meets an idle multiplier
    assert property (@(posedge clock) disable iff (reset)
        mulStart |-> state == mduPkg::mulIdle)
        else $error("multiply start while the multiplier was still running");

endmodule

/* hdl/mduResultSel.sv */
`timescale 1ns/1ps
`include "mdu_consts.svh"

module mduResultSel (
    input  logic         clock,
    input  logic         reset,
    input  logic         flush,
    input  logic         divDone,
    input  logic         mulDone,
    input  mduPkg::xlenT quotient,
    input  mduPkg::xlenT remainder,
    input  mduPkg::xlenT productLow,
    input  mduPkg::xlenT productHigh,
    input  logic         selHigh,
    input  logic         selRem,
    input  logic         wordOp,
    input  logic         divByZero,
    input  logic         divOverflow,
    input  mduPkg::xlenT opA,
    output logic         outValid,
    output mduPkg::xlenT result
);
    mduPkg::xlenT divValue;
    mduPkg::xlenT mulValue;
    mduPkg::xlenT rawValue;
    mduPkg::xlenT extValue;

    // fixed RISC-V results for x/0 and MIN/-1
    always_comb begin
        if (selRem) begin
            if (divByZero) begin
                divValue = opA;
            end else if (divOverflow) begin
                divValue = '0;
            end else begin
                divValue = remainder;
            end
        end else begin
            if (divByZero) begin
                divValue = '1;
            end else if (divOverflow) begin
                divValue = opA;
            end else begin
                divValue = quotient;
            end
        end
    end

    assign mulValue = selHigh ? productHigh : productLow;
    assign rawValue = divDone ? divValue : mulValue;
    assign extValue = wordOp ?
        {{(`MDU_XLEN-`MDU_WLEN){rawValue[`MDU_WLEN-1]}}, rawValue[`MDU_WLEN-1:0]} :
        rawValue;

    always_ff @(posedge clock) begin
        if (reset) begin
            outValid <= 1'b0;
        end else begin
            outValid <= (divDone || mulDone) && !flush;  // aborted op gives no pulse
        end
    end

    always_ff @(posedge clock) begin
        if (divDone || mulDone) begin
            result <= extValue;
        end
    end

    // only one datapath runs per accepted request
    assert property (@(posedge clock) disable iff (reset) !(divDone && mulDone))
        else $error("divider and multiplier finished together");

endmodule

/* hdl/mduTop.sv */
`timescale 1ns/1ps

module mduTop (
    input  logic           clock,
    input  logic           reset,
    input  logic           start,
    input  logic           flush,
    input  mduPkg::funct3T funct3,
    input  logic           isWord,
    input  mduPkg::xlenT   operandA,
    input  mduPkg::xlenT   operandB,
    output logic           ready,
    output logic           outValid,
    output mduPkg::xlenT   result
);
    logic             divStart;
    logic             mulStart;
    mduPkg::xlenT     opA;
    mduPkg::xlenT     opB;
    logic             wordOp;
    mduPkg::signModeT signMode;
    logic             selHigh;
    logic             selRem;
    logic             divByZero;
    logic             divOverflow;
    logic             divDone;
    logic             mulDone;
    mduPkg::xlenT     quotient;
    mduPkg::xlenT     remainder;
    mduPkg::xlenT     productLow;
    mduPkg::xlenT     productHigh;

    mduDecode decode (
        .clock(clock), .reset(reset), .start(start), .flush(flush),
        .funct3(funct3), .isWord(isWord), .operandA(operandA), .operandB(operandB),
        .outValid(outValid), .ready(ready), .divStart(divStart), .mulStart(mulStart),
        .opA(opA), .opB(opB), .wordOp(wordOp), .signMode(signMode),
        .selHigh(selHigh), .selRem(selRem),
        .divByZero(divByZero), .divOverflow(divOverflow)
    );

    iterDivider divider (
        .clock(clock), .reset(reset), .divStart(divStart), .flush(flush),
        .opA(opA), .opB(opB), .wordOp(wordOp), .signMode(signMode),
        .divDone(divDone), .quotient(quotient), .remainder(remainder)
    );

    seqMultiplier multiplier (
        .clock(clock), .reset(reset), .mulStart(mulStart), .flush(flush),
        .opA(opA), .opB(opB), .wordOp(wordOp), .signMode(signMode),
        .mulDone(mulDone), .productLow(productLow), .productHigh(productHigh)
    );

    mduResultSel resultSel (
        .clock(clock), .reset(reset), .flush(flush),
        .divDone(divDone), .mulDone(mulDone),
        .quotient(quotient), .remainder(remainder),
        .productLow(productLow), .productHigh(productHigh),
        .selHigh(selHigh), .selRem(selRem), .wordOp(wordOp),
        .divByZero(divByZero), .divOverflow(divOverflow), .opA(opA),
        .outValid(outValid), .result(result)
    );

endmodule

/* sim/mduTb.sv */
`timescale 1ns/1ps
`include "mdu_consts.svh"

module mduTb;
    localparam int NUM_OPS     = 400;
    localparam int CYCLE_LIMIT = NUM_OPS * 70 + 100;

    logic           clock;
    logic           reset;
    logic           start;
    logic           flush;
    mduPkg::funct3T funct3;
    logic           isWord;
    mduPkg::xlenT   operandA;
    mduPkg::xlenT   operandB;
    logic           ready;
    logic           outValid;
    mduPkg::xlenT   result;

    integer seed;
    integer cycles;
    integer opCount;
    integer valueErrors;
    integer timingErrors;

    mduTop UUT (
        .clock(clock), .reset(reset), .start(start), .flush(flush),
        .funct3(funct3), .isWord(isWord), .operandA(operandA), .operandB(operandB),
        .ready(ready), .outValid(outValid), .result(result)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles, an operation never finished", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // expected result from wide arithmetic and the M extension rules
    function automatic mduPkg::xlenT refModel(input mduPkg::funct3T f, input logic w,
                                              input mduPkg::xlenT a, input mduPkg::xlenT b);
        logic signed [127:0] ea;
        logic signed [127:0] eb;
        logic signed [127:0] minVal;
        logic signed [127:0] prod;
        logic signed [127:0] q;
        logic signed [127:0] r;
        logic                aSigned;
        logic                bSigned;
        mduPkg::xlenT        res;
        aSigned = (f != `MDU_FUNCT_MULHU) && (f != `MDU_FUNCT_DIVU) && (f != `MDU_FUNCT_REMU);
        bSigned = aSigned && (f != `MDU_FUNCT_MULHSU);
        if (w) begin
            ea = aSigned ? {{96{a[31]}}, a[31:0]} : {96'b0, a[31:0]};
            eb = bSigned ? {{96{b[31]}}, b[31:0]} : {96'b0, b[31:0]};
            minVal = -(128'sd1 <<< 31);
        end else begin
            ea = aSigned ? {{64{a[63]}}, a} : {64'b0, a};
            eb = bSigned ? {{64{b[63]}}, b} : {64'b0, b};
            minVal = -(128'sd1 <<< 63);
        end
        prod = ea * eb;
        if (eb == 0) begin
            q = -1;   // all ones
            r = ea;
        end else if (bSigned && ea == minVal && eb == -1) begin
            q = ea;   // overflow keeps the dividend
            r = 0;
        end else begin
            q = ea / eb;   // truncates toward zero
            r = ea % eb;
        end
        case (f)
            `MDU_FUNCT_MUL: res = prod[63:0];
            `MDU_FUNCT_MULH, `MDU_FUNCT_MULHSU, `MDU_FUNCT_MULHU:
                res = w ? prod[63:0] : prod[127:64];
            `MDU_FUNCT_DIV, `MDU_FUNCT_DIVU: res = q[63:0];
            default: res = r[63:0];
        endcase
        if (w) begin
            res = {{32{res[31]}}, res[31:0]};
        end
        return res;
    endfunction

    // plain random values mixed with corner values at both widths
    function automatic mduPkg::xlenT pickOperand();
        integer       sel;
        mduPkg::xlenT v;
        sel = $unsigned($random(seed)) % 10;
        v = {$random(seed), $random(seed)};
        case (sel)
            0: return '0;
            1: return 64'd1;
            2: return '1;
            3: return 64'h8000_0000_0000_0000;
            4: return {v[63:32], 32'h8000_0000};
            5: return {v[63:32], 32'hffff_ffff};
            6: return v & 64'hff;
            default: return v;
        endcase
    endfunction

    task automatic runOp(input mduPkg::funct3T f, input logic w, input mduPkg::xlenT a,
                         input mduPkg::xlenT b, input logic poke);
        mduPkg::xlenT expected;
        integer       n;
        integer       k;
        expected = refModel(f, w, a, b);
        n = w ? `MDU_WORD_STEPS : `MDU_DWORD_STEPS;
        opCount = opCount + 1;
        @(posedge clock);
        start    <= 1'b1;
        funct3   <= f;
        isWord   <= w;
        operandA <= a;
        operandB <= b;
        for (k = 0; k <= n + 3; k++) begin
            @(posedge clock);   // edge k, edge 0 accepts
            start <= poke && (k == 3);   // must be ignored while busy
            if (k == 0 || (poke && k == 3)) begin
                operandA <= {$random(seed), $random(seed)};
                operandB <= {$random(seed), $random(seed)};
            end
            @(negedge clock);
            if (k < n + 2) begin
                if (outValid !== 1'b0 || ready !== 1'b0) begin
                    $display("outValid %b ready %b at cycle %0d, expected both low",
                             outValid, ready, k);
                    timingErrors = timingErrors + 1;
                end
            end else if (k == n + 2) begin
                if (outValid !== 1'b1 || ready !== 1'b0) begin
                    $display("no outValid pulse %0d cycles after acceptance", n + 2);
                    timingErrors = timingErrors + 1;
                end else if (result !== expected) begin
                    $display("MISMATCH result: got %h expected %h (funct3 %0d word %0b a %h b %h)",
                             result, expected, f, w, a, b);
                    valueErrors = valueErrors + 1;
                end
            end else if (outValid !== 1'b0 || ready !== 1'b1) begin
                $display("outValid not a single pulse or ready still low after the result");
                timingErrors = timingErrors + 1;
            end
        end
    endtask

    task automatic flushOp(input mduPkg::funct3T f, input logic w, input mduPkg::xlenT a,
                           input mduPkg::xlenT b);
        integer delay;
        integer k;
        delay = 1 + ($random(seed) & 31);   // stays inside the busy window
        @(posedge clock);
        start    <= 1'b1;
        funct3   <= f;
        isWord   <= w;
        operandA <= a;
        operandB <= b;
        @(posedge clock);
        start <= 1'b0;
        repeat (delay) @(posedge clock);
        flush <= 1'b1;
        @(posedge clock);
        flush <= 1'b0;
        @(negedge clock);
        if (ready !== 1'b1) begin
            $display("ready still low after flush");
            timingErrors = timingErrors + 1;
        end
        for (k = 0; k < 70; k++) begin
            @(negedge clock);
            if (outValid !== 1'b0) begin
                $display("outValid pulse from a flushed operation");
                timingErrors = timingErrors + 1;
            end
        end
    endtask

    initial begin
        seed = 32'h848a_45e9;
        cycles = 0;
        opCount = 0;
        valueErrors = 0;
        timingErrors = 0;
        reset = 1'b1;
        start = 1'b0;
        flush = 1'b0;
        funct3 = '0;
        isWord = 1'b0;
        operandA = '0;
        operandB = '0;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        if (ready !== 1'b1 || outValid !== 1'b0) begin
            $display("ready low or outValid high after reset");
            timingErrors = timingErrors + 1;
        end

        // x/0 and MIN/-1 for every divide at both widths
        for (int w = 0; w < 2; w++) begin
            for (int f = 4; f < 8; f++) begin
                runOp(mduPkg::funct3T'(f), w[0], pickOperand(), '0, 1'b0);
                runOp(mduPkg::funct3T'(f), w[0], w ? {$random(seed), 32'h8000_0000} :
                      64'h8000_0000_0000_0000, '1, 1'b0);
            end
        end

        for (int i = 0; i < 300; i++) begin
            runOp(mduPkg::funct3T'($random(seed) & 7), $random(seed) & 1,
                  pickOperand(), pickOperand(), ($random(seed) & 3) == 0);
        end

        for (int i = 0; i < 12; i++) begin
            flushOp(mduPkg::funct3T'($random(seed) & 7), $random(seed) & 1,
                    pickOperand(), pickOperand());
            runOp(mduPkg::funct3T'($random(seed) & 7), $random(seed) & 1,
                  pickOperand(), pickOperand(), 1'b0);
        end

        $display("ops %0d, value errors %0d, timing errors %0d",
                 opCount, valueErrors, timingErrors);
        if (valueErrors == 0 && timingErrors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+hdl
hdl/mduPkg.sv
hdl/mduDecode.sv
hdl/iterDivider.sv
hdl/seqMultiplier.sv
hdl/mduResultSel.sv
hdl/mduTop.sv
sim/mduTb.sv
